// ==== sim.f ====
icache_pkg.sv
icache_line_store.sv
axi_line_reader.sv
icache_miss_ctrl.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_icache -f sim.f &&
./obj_dir/Vtb_icache | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run passed" ||
{ echo "run did not pass"; exit 1; }

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    import icache_pkg::*;

    localparam logic [31:0] mem_pattern    = 32'hA5C3_0F96;
    localparam int          num_entries    = 22;
    localparam int          timeout_cycles = num_entries * 40;

    // address, fence before request, expected hit, expected AR count
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              fence;
        logic              hit;
        logic [7:0]        ars;
    } entry_t;

    logic              M_AXI_ACLK;
    logic              M_AXI_ARESETN;
    logic              req;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              valid;
    logic              fence_i;
    logic [addr_w-1:0] M_AXI_ARADDR;
    logic              M_AXI_ARVALID;
    logic              M_AXI_ARREADY;
    logic [7:0]        M_AXI_ARLEN;
    logic [2:0]        M_AXI_ARSIZE;
    logic [1:0]        M_AXI_ARBURST;
    logic [data_w-1:0] M_AXI_RDATA;
    logic [1:0]        M_AXI_RRESP;
    logic              M_AXI_RVALID;
    logic              M_AXI_RLAST;
    logic              M_AXI_RREADY;

    entry_t            stim [num_entries];
    int                ar_count     = 0;
    int                cycle_count  = 0;
    int                wait_cycles;
    logic              prev_arvalid = 1'b0;
    logic              prev_arready = 1'b0;
    logic [addr_w-1:0] prev_araddr  = '0;

    icache_top u_dut (.*);

    tb_axi_mem #(.mem_pattern(mem_pattern)) u_mem (.*);

    always #2 M_AXI_ACLK = ~M_AXI_ACLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    begin
        if (got !== exp)
        begin
            $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped on the first mismatch");
        end
    end
    endtask

    //----------------------------------------------------------------------
    // AR channel monitor sampled mid cycle
    //----------------------------------------------------------------------
    always @(negedge M_AXI_ACLK)
    begin
        if (M_AXI_ARESETN)
        begin
            // a pending request must be held with the same address
            if (prev_arvalid && !prev_arready)
            begin
                check_value("M_AXI_ARVALID", 32'(M_AXI_ARVALID), 32'd1);
                check_value("M_AXI_ARADDR", M_AXI_ARADDR, prev_araddr);
            end
            if (M_AXI_ARVALID && M_AXI_ARREADY)
            begin
                ar_count++;
                check_value("M_AXI_ARADDR", M_AXI_ARADDR, addr & 32'hFFFF_FFF0);
                check_value("M_AXI_ARLEN", 32'(M_AXI_ARLEN), 32'd3);
                check_value("M_AXI_ARSIZE", 32'(M_AXI_ARSIZE), 32'd2);
                check_value("M_AXI_ARBURST", 32'(M_AXI_ARBURST), 32'd1);
            end
        end
        prev_arvalid = M_AXI_ARVALID;
        prev_arready = M_AXI_ARREADY;
        prev_araddr  = M_AXI_ARADDR;
    end

    always @(posedge M_AXI_ACLK)
    begin
        cycle_count++;
        if (cycle_count > timeout_cycles)
        begin
            $display("timeout: the fetch did not finish within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        M_AXI_ACLK    = 1'b0;
        M_AXI_ARESETN = 1'b0;
        req           = 1'b1;
        addr          = '0;
        fence_i       = 1'b0;
        stim = '{
            // cold miss then hits on the other words of the line
            '{32'h0000_1000, 1'b0, 1'b0, 8'd1},
            '{32'h0000_1004, 1'b0, 1'b1, 8'd1},
            '{32'h0000_1008, 1'b0, 1'b1, 8'd1},
            '{32'h0000_100C, 1'b0, 1'b1, 8'd1},
            '{32'h0000_1010, 1'b0, 1'b0, 8'd2},
            '{32'h0000_101C, 1'b0, 1'b1, 8'd2},
            '{32'h0000_1024, 1'b0, 1'b0, 8'd3},
            '{32'h0000_1038, 1'b0, 1'b0, 8'd4},
            // index 0 conflict evicts line 0x1000
            '{32'h0000_2000, 1'b0, 1'b0, 8'd5},
            '{32'h0000_2008, 1'b0, 1'b1, 8'd5},
            '{32'h0000_1004, 1'b0, 1'b0, 8'd6},
            '{32'h0000_1014, 1'b0, 1'b1, 8'd6},
            '{32'h0000_1020, 1'b0, 1'b1, 8'd6},
            '{32'h0000_103C, 1'b0, 1'b1, 8'd6},
            // fence drops all lines
            '{32'h0000_1000, 1'b1, 1'b0, 8'd7},
            '{32'h0000_1018, 1'b0, 1'b0, 8'd8},
            '{32'h0000_1028, 1'b0, 1'b0, 8'd9},
            '{32'h0000_1030, 1'b0, 1'b0, 8'd10},
            '{32'h0000_100C, 1'b0, 1'b1, 8'd10},
            '{32'h8000_0FF4, 1'b0, 1'b0, 8'd11},
            '{32'h8000_0FF0, 1'b0, 1'b1, 8'd11},
            '{32'h0000_1034, 1'b0, 1'b0, 8'd12}
        };
        // a request held through reset must not hit
        repeat (2) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        check_value("valid", 32'(valid), 32'd0);
        @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        req           = 1'b0;
        @(negedge M_AXI_ACLK);
        check_value("M_AXI_ARVALID", 32'(M_AXI_ARVALID), 32'd0);
        check_value("M_AXI_RREADY", 32'(M_AXI_RREADY), 32'd0);

        for (int i = 0; i < num_entries; i++)
        begin
            @(posedge M_AXI_ACLK);
            #1;
            if (stim[i].fence)
            begin
                req     = 1'b0;
                fence_i = 1'b1;
                @(posedge M_AXI_ACLK);
                #1;
                fence_i = 1'b0;
            end
            req  = 1'b1;
            addr = stim[i].addr;
            // a hit shows valid in the cycle of the request
            @(negedge M_AXI_ACLK);
            wait_cycles = 0;
            while (!valid)
            begin
                @(negedge M_AXI_ACLK);
                wait_cycles++;
            end
            check_value("hit", 32'(wait_cycles == 0), 32'(stim[i].hit));
            check_value("data", data, stim[i].addr ^ mem_pattern);
            check_value("ar_count", ar_count, 32'(stim[i].ars));
        end
        @(posedge M_AXI_ACLK);
        #1;
        req = 1'b0;

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
    parameter logic [31:0] mem_pattern = 32'h0
) (
    input  logic                          M_AXI_ACLK,
    input  logic                          M_AXI_ARESETN,
    input  logic [icache_pkg::addr_w-1:0] M_AXI_ARADDR,
    input  logic                          M_AXI_ARVALID,
    output logic                          M_AXI_ARREADY,
    input  logic [7:0]                    M_AXI_ARLEN,
    output logic [icache_pkg::data_w-1:0] M_AXI_RDATA,
    output logic [1:0]                    M_AXI_RRESP,
    output logic                          M_AXI_RVALID,
    output logic                          M_AXI_RLAST,
    input  logic                          M_AXI_RREADY
);

    import icache_pkg::*;

    logic [addr_w-1:0] addr_q;
    int                len_q;
    int                stall;
    int unsigned       seed_ret;

    // outputs change 1 ns after the rising edge
    task automatic step_cycle();
    begin
        @(posedge M_AXI_ACLK);
        #1;
    end
    endtask

    task automatic stall_cycles();
    begin
        stall = $urandom_range(0, 3);
        repeat (stall)
        begin
            step_cycle();
        end
    end
    endtask

    //----------------------------------------------------------------------
    // single burst slave with memory word = byte address xor pattern
    //----------------------------------------------------------------------
    initial
    begin
        M_AXI_ARREADY = 1'b0;
        M_AXI_RDATA   = '0;
        M_AXI_RRESP   = 2'b00;
        M_AXI_RVALID  = 1'b0;
        M_AXI_RLAST   = 1'b0;
        seed_ret      = $urandom(95);
        forever
        begin
            step_cycle();
            if (M_AXI_ARESETN && M_AXI_ARVALID)
            begin
                stall_cycles();
                addr_q        = M_AXI_ARADDR;
                len_q         = int'(M_AXI_ARLEN);
                M_AXI_ARREADY = 1'b1;
                step_cycle();
                M_AXI_ARREADY = 1'b0;
                for (int beat = 0; beat <= len_q; beat++)
                begin
                    M_AXI_RVALID = 1'b0;
                    M_AXI_RLAST  = 1'b0;
                    stall_cycles();
                    M_AXI_RDATA  = (addr_q + 32'(4 * beat)) ^ mem_pattern;
                    M_AXI_RLAST  = (beat == len_q);
                    M_AXI_RVALID = 1'b1;
                    // beat moves on the first edge with RREADY high
                    while (!M_AXI_RREADY)
                    begin
                        step_cycle();
                    end
                    step_cycle();
                end
                M_AXI_RVALID = 1'b0;
                M_AXI_RLAST  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                          M_AXI_ACLK,
    input  logic                          M_AXI_ARESETN,
    // fetch side
    input  logic                          req,
    input  logic [icache_pkg::addr_w-1:0] addr,
    output logic [icache_pkg::data_w-1:0] data,
    output logic                          valid,
    input  logic                          fence_i,
    // read address channel
    output logic [icache_pkg::addr_w-1:0] M_AXI_ARADDR,
    output logic                          M_AXI_ARVALID,
    input  logic                          M_AXI_ARREADY,
    output logic [7:0]                    M_AXI_ARLEN,
    output logic [2:0]                    M_AXI_ARSIZE,
    output logic [1:0]                    M_AXI_ARBURST,
    // read data channel
    input  logic [icache_pkg::data_w-1:0] M_AXI_RDATA,
    input  logic [1:0]                    M_AXI_RRESP,
    input  logic                          M_AXI_RVALID,
    input  logic                          M_AXI_RLAST,
    output logic                          M_AXI_RREADY
);

    import icache_pkg::*;

    logic                  hit;
    logic [data_w-1:0]     hit_data;
    logic                  fill_start;
    logic [addr_w-1:0]     line_addr;
    logic [index_bits-1:0] fill_index;
    logic [tag_bits-1:0]   fill_tag;
    logic                  fence;
    logic                  beat_valid;
    logic [beat_bits-1:0]  beat_idx;
    logic [data_w-1:0]     beat_data;
    logic                  fill_done;

    icache_miss_ctrl u_ctrl (.M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .req(req), .addr(addr), .hit(hit), .fill_done(fill_done), .fence_i(fence_i),
        .fill_start(fill_start), .line_addr(line_addr), .fill_index(fill_index),
        .fill_tag(fill_tag), .fence(fence));

    axi_line_reader u_reader (.M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .fill_start(fill_start), .line_addr(line_addr), .M_AXI_ARADDR(M_AXI_ARADDR),
        .M_AXI_ARVALID(M_AXI_ARVALID), .M_AXI_ARREADY(M_AXI_ARREADY),
        .M_AXI_ARLEN(M_AXI_ARLEN), .M_AXI_ARSIZE(M_AXI_ARSIZE), .M_AXI_ARBURST(M_AXI_ARBURST),
        .M_AXI_RDATA(M_AXI_RDATA), .M_AXI_RRESP(M_AXI_RRESP), .M_AXI_RVALID(M_AXI_RVALID),
        .M_AXI_RLAST(M_AXI_RLAST), .M_AXI_RREADY(M_AXI_RREADY), .beat_valid(beat_valid),
        .beat_idx(beat_idx), .beat_data(beat_data), .fill_done(fill_done));

    icache_line_store u_store (.M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .lookup_addr(addr), .beat_valid(beat_valid), .beat_idx(beat_idx),
        .beat_data(beat_data), .fill_done(fill_done), .fill_index(fill_index),
        .fill_tag(fill_tag), .fence(fence), .hit(hit), .hit_data(hit_data));

    // hit answers in the same cycle
    assign valid = hit && req;
    assign data  = hit_data;

endmodule

`default_nettype wire

// ==== icache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_miss_ctrl (
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  logic                              req,
    input  logic [icache_pkg::addr_w-1:0]     addr,
    input  logic                              hit,
    input  logic                              fill_done,
    input  logic                              fence_i,
    output logic                              fill_start,
    output logic [icache_pkg::addr_w-1:0]     line_addr,
    output logic [icache_pkg::index_bits-1:0] fill_index,
    output logic [icache_pkg::tag_bits-1:0]   fill_tag,
    output logic                              fence
);

    import icache_pkg::*;

    logic busy;
    logic miss;

    // a new miss is only taken while no refill runs
    assign miss = req && !hit && !busy;

    //----------------------------------------------------------------------
    // refill sequencing
    //----------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            busy       <= 1'b0;
            fill_start <= 1'b0;
        end
        else
        begin
            fill_start <= miss;
            if (miss)
            begin
                busy <= 1'b1;
            end
            else if (fill_done)
            begin
                busy <= 1'b0;
            end
        end
    end

    // line aligned address of the missing fetch
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (miss)
        begin
            line_addr <= {addr[addr_w-1:offset_bits], {offset_bits{1'b0}}};
        end
    end

    assign fill_index = line_addr[offset_bits +: index_bits];
    assign fill_tag   = line_addr[addr_w-1 -: tag_bits];

    // fence ignored in the middle of a refill
    assign fence = fence_i && !busy;

endmodule

`default_nettype wire

// ==== axi_line_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_line_reader (
    input  logic                             M_AXI_ACLK,
    input  logic                             M_AXI_ARESETN,
    input  logic                             fill_start,
    input  logic [icache_pkg::addr_w-1:0]    line_addr,
    // read address channel
    output logic [icache_pkg::addr_w-1:0]    M_AXI_ARADDR,
    output logic                             M_AXI_ARVALID,
    input  logic                             M_AXI_ARREADY,
    output logic [7:0]                       M_AXI_ARLEN,
    output logic [2:0]                       M_AXI_ARSIZE,
    output logic [1:0]                       M_AXI_ARBURST,
    // read data channel
    input  logic [icache_pkg::data_w-1:0]    M_AXI_RDATA,
    input  logic [1:0]                       M_AXI_RRESP,
    input  logic                             M_AXI_RVALID,
    input  logic                             M_AXI_RLAST,
    output logic                             M_AXI_RREADY,
    // beats towards the line store
    output logic                             beat_valid,
    output logic [icache_pkg::beat_bits-1:0] beat_idx,
    output logic [icache_pkg::data_w-1:0]    beat_data,
    output logic                             fill_done
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t               state;
    logic [addr_w-1:0]    araddr;
    logic [beat_bits-1:0] beat_cnt;

    //----------------------------------------------------------------------
    // burst sequence
    //----------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            state    <= st_idle;
            beat_cnt <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (fill_start)
                    begin
                        state    <= st_addr;
                        beat_cnt <= '0;
                    end
                end
                // hold ARVALID and address until accepted
                st_addr:
                begin
                    if (M_AXI_ARREADY)
                    begin
                        state <= st_data;
                    end
                end
                st_data:
                begin
                    if (beat_valid)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (M_AXI_RLAST)
                        begin
                            state <= st_idle;
                        end
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // line address for the AR channel
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (fill_start && (state == st_idle))
        begin
            araddr <= line_addr;
        end
    end

    assign M_AXI_ARADDR  = araddr;
    assign M_AXI_ARVALID = (state == st_addr);
    assign M_AXI_ARLEN   = axi_len_line;
    assign M_AXI_ARSIZE  = axi_size_word;
    assign M_AXI_ARBURST = axi_burst_incr;
    assign M_AXI_RREADY  = (state == st_data);

    // beats go straight to the line store and RRESP is ignored
    assign beat_valid = M_AXI_RVALID && M_AXI_RREADY;
    assign beat_idx   = beat_cnt;
    assign beat_data  = M_AXI_RDATA;
    assign fill_done  = beat_valid && M_AXI_RLAST;

endmodule

`default_nettype wire

// ==== icache_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_line_store (
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  logic [icache_pkg::addr_w-1:0]     lookup_addr,
    input  logic                              beat_valid,
    input  logic [icache_pkg::beat_bits-1:0]  beat_idx,
    input  logic [icache_pkg::data_w-1:0]     beat_data,
    input  logic                              fill_done,
    input  logic [icache_pkg::index_bits-1:0] fill_index,
    input  logic [icache_pkg::tag_bits-1:0]   fill_tag,
    input  logic                              fence,
    output logic                              hit,
    output logic [icache_pkg::data_w-1:0]     hit_data
);

    import icache_pkg::*;

    // line storage
    logic [data_w-1:0]   data_mem [num_lines][line_words];
    logic [tag_bits-1:0] tag_mem  [num_lines];
    logic [num_lines-1:0] valid_bits;

    logic [tag_bits-1:0]   lookup_tag;
    logic [index_bits-1:0] lookup_index;
    logic [beat_bits-1:0]  lookup_word;

    //----------------------------------------------------------------------
    // lookup
    //----------------------------------------------------------------------
    assign lookup_tag   = lookup_addr[addr_w-1 -: tag_bits];
    assign lookup_index = lookup_addr[offset_bits +: index_bits];
    // fetches are word aligned so byte bits [1:0] are ignored
    assign lookup_word  = lookup_addr[2 +: beat_bits];

    assign hit      = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign hit_data = data_mem[lookup_index][lookup_word];

    //----------------------------------------------------------------------
    // refill
    //----------------------------------------------------------------------
    // beats land straight in the line being refilled
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (beat_valid)
        begin
            data_mem[fill_index][beat_idx] <= beat_data;
        end
    end

    // tag written together with the last beat
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (fill_done)
        begin
            tag_mem[fill_index] <= fill_tag;
        end
    end

    // valid bits
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            valid_bits <= '0;
        end
        else if (fence)
        begin
            valid_bits <= '0;
        end
        else if (fill_done)
        begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    //----------------------------------------------------------------------
    // cache geometry
    //----------------------------------------------------------------------
    localparam int addr_w      = 32;
    localparam int data_w      = 32;
    localparam int line_words  = 4;
    localparam int num_lines   = 4;

    // address split into tag, index and byte offset
    localparam int offset_bits = 4;
    localparam int index_bits  = 2;
    localparam int tag_bits    = addr_w - index_bits - offset_bits;

    // word position inside a line
    localparam int beat_bits   = 2;

    //----------------------------------------------------------------------
    // axi read burst codes
    //----------------------------------------------------------------------
    // one line per burst
    localparam logic [7:0] axi_len_line   = 8'(line_words - 1);
    // 4 bytes per beat
    localparam logic [2:0] axi_size_word  = 3'b010;
    localparam logic [1:0] axi_burst_incr = 2'b01;

endpackage

`default_nettype wire
